// File: verilog/game_pkg.sv
// Game package with FSM states, screen geometry, target size and game limits
`default_nettype none

package game_pkg;

    // Control FSM states
    typedef enum logic [1:0] {
        START_SCREEN = 2'b00,
        GAME_RUNNING = 2'b01,
        GAME_OVER    = 2'b10
    } game_state_t;

    localparam int COORD_W = 12;                        // Any x or y position
    localparam logic [COORD_W-1:0] SCREEN_W = 12'd800;  // Visible playfield
    localparam logic [COORD_W-1:0] SCREEN_H = 12'd600;

    // Start button box, lower edge inclusive, upper edge exclusive
    localparam logic [COORD_W-1:0] START_BTN_X = 12'd350;
    localparam logic [COORD_W-1:0] START_BTN_Y = 12'd280;
    localparam logic [COORD_W-1:0] START_BTN_W = 12'd100;
    localparam logic [COORD_W-1:0] START_BTN_H = 12'd40;

    // Square target, anchored at its top-left corner
    localparam logic [COORD_W-1:0] TARGET_SIZE    = 12'd32;
    localparam logic [COORD_W-1:0] TARGET_RESET_X = 12'd100;
    localparam logic [COORD_W-1:0] TARGET_RESET_Y = 12'd100;
    // Count of legal top-left positions per axis
    localparam logic [COORD_W-1:0] TARGET_SPAN_X = SCREEN_W - TARGET_SIZE + 12'd1;
    localparam logic [COORD_W-1:0] TARGET_SPAN_Y = SCREEN_H - TARGET_SIZE + 12'd1;
    localparam int RAND_W = 10;                         // Raw random bits per axis

    localparam int SCORE_W = 4;
    localparam logic [SCORE_W-1:0] WIN_SCORE = 4'd5;    // Hits needed to win
    localparam int TIME_W = 8;
    localparam logic [TIME_W-1:0] GAME_TIME_TICKS = 8'd20;  // Frames per game

    localparam int LFSR_W = 16;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;

endpackage

`default_nettype wire

// File: verilog/mouse_click_capture.sv
// Mouse click capture that acknowledges four-phase requests, latches coordinates and pulses a click
`timescale 1ns/1ns
`default_nettype none

module mouse_click_capture import game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               mouse_req,
    input  logic [COORD_W-1:0] click_x,
    input  logic [COORD_W-1:0] click_y,
    output logic               mouse_ack,
    output logic               click_valid,
    output logic [COORD_W-1:0] pos_x,
    output logic [COORD_W-1:0] pos_y
);

    logic req_new;   // Request seen but not yet acknowledged

    assign req_new = mouse_req && !mouse_ack;

    // Ack simply follows req one edge later
    always_ff @(posedge clk) begin
        if (rst) begin
            mouse_ack   <= 1'b0;
            click_valid <= 1'b0;
        end else begin
            mouse_ack   <= mouse_req;
            click_valid <= req_new;     // One pulse per handshake
        end
    end

    // Coordinates held stable by sender while req high
    always_ff @(posedge clk) begin
        if (req_new) begin
            pos_x <= click_x;
            pos_y <= click_y;
        end
    end

    // Four-phase rule seen from our side
    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(mouse_ack) |-> $past(mouse_req)
    );

endmodule

`default_nettype wire

// File: verilog/area_hit_detect.sv
// Hit detector, tests a click against the start button and the target square
`timescale 1ns/1ns
`default_nettype none

module area_hit_detect import game_pkg::*; (
    input  logic [COORD_W-1:0] pos_x,
    input  logic [COORD_W-1:0] pos_y,
    input  logic [COORD_W-1:0] target_x,
    input  logic [COORD_W-1:0] target_y,
    output logic               start_hit,
    output logic               target_hit
);

    // One extra bit so the right edge never wraps
    logic [COORD_W:0] target_x_end;
    logic [COORD_W:0] target_y_end;
    logic             start_in_x;
    logic             start_in_y;
    logic             target_in_x;
    logic             target_in_y;

    assign target_x_end = {1'b0, target_x} + {1'b0, TARGET_SIZE};
    assign target_y_end = {1'b0, target_y} + {1'b0, TARGET_SIZE};

    // Fixed button box
    assign start_in_x = (pos_x >= START_BTN_X) && (pos_x < START_BTN_X + START_BTN_W);
    assign start_in_y = (pos_y >= START_BTN_Y) && (pos_y < START_BTN_Y + START_BTN_H);

    // Moving target, exclusive far edge
    assign target_in_x = (pos_x >= target_x) && ({1'b0, pos_x} < target_x_end);
    assign target_in_y = (pos_y >= target_y) && ({1'b0, pos_y} < target_y_end);

    assign start_hit  = start_in_x && start_in_y;
    assign target_hit = target_in_x && target_in_y;

endmodule

`default_nettype wire

// File: verilog/target_placer.sv
// Target placer, moves the target square to an LFSR-chosen spot inside the playfield
`timescale 1ns/1ns
`default_nettype none

module target_placer import game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               game_start,
    input  logic               score_pulse,
    output logic [COORD_W-1:0] target_x,
    output logic [COORD_W-1:0] target_y
);

    logic [LFSR_W-1:0]  lfsr;
    logic               feedback;
    logic [COORD_W-1:0] raw_x;
    logic [COORD_W-1:0] raw_y;
    logic [COORD_W-1:0] next_x;
    logic [COORD_W-1:0] next_y;

    // Taps 16,14,13,11, maximal length
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[LFSR_W-2:0], feedback};   // Free running
        end
    end

    // Ten bits per axis, y slice rotated off the x slice
    assign raw_x = {{(COORD_W-RAND_W){1'b0}}, lfsr[RAND_W-1:0]};
    assign raw_y = {{(COORD_W-RAND_W){1'b0}}, lfsr[3:0], lfsr[15:10]};

    // Raw value below twice the span, one subtract is enough
    assign next_x = (raw_x >= TARGET_SPAN_X) ? raw_x - TARGET_SPAN_X : raw_x;
    assign next_y = (raw_y >= TARGET_SPAN_Y) ? raw_y - TARGET_SPAN_Y : raw_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            target_x <= TARGET_RESET_X;
            target_y <= TARGET_RESET_Y;
        end else if (game_start || score_pulse) begin
            target_x <= next_x;     // Whole square stays on screen
            target_y <= next_y;
        end
    end

endmodule

`default_nettype wire

// File: verilog/score_timer.sv
// Score and timer block that counts target hits and frame ticks and flags a finished game
`timescale 1ns/1ns
`default_nettype none

module score_timer import game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               game_start,
    input  logic               score_pulse,
    input  logic               game_enable,
    input  logic               frame_tick,
    output logic [SCORE_W-1:0] score,
    output logic [TIME_W-1:0]  time_left,
    output logic               game_finished
);

    logic tick_count;   // Tick that actually lowers the timer

    assign tick_count = game_enable && frame_tick && (time_left != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            score     <= '0;
            time_left <= '0;
        end else if (game_start) begin
            score     <= '0;
            time_left <= GAME_TIME_TICKS;   // Fresh countdown
        end else begin
            if (score_pulse) begin
                score <= score + 1'b1;
            end
            if (tick_count) begin
                time_left <= time_left - 1'b1;
            end
        end
    end

    // Time out or goal reached
    assign game_finished = (time_left == '0) || (score == WIN_SCORE);

    // FSM must stop scoring once the goal flag is up
    score_capped: assert property (
        @(posedge clk) disable iff (rst)
        score <= WIN_SCORE
    );

endmodule

`default_nettype wire

// File: verilog/game_control_fsm.sv
// Game control FSM that steps through start screen, running game and game over
`timescale 1ns/1ns
`default_nettype none

module game_control_fsm import game_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic click_valid,
    input  logic start_hit,
    input  logic target_hit,
    input  logic game_finished,
    output logic start_screen_enable,
    output logic game_enable,
    output logic game_end_enable,
    output logic game_start,
    output logic score_pulse
);

    game_state_t state;
    game_state_t next_state;
    logic        start_click;
    logic        score_click;
    logic        running_done;

    // Timer still stale in the game_start cycle so its finish is ignored there
    assign running_done = game_finished && !game_start;

    assign start_click = (state == START_SCREEN) && click_valid && start_hit;
    assign score_click = (state == GAME_RUNNING) && click_valid && target_hit
                         && !running_done;

    always_comb begin
        next_state = state;
        case (state)
            START_SCREEN: begin
                if (start_click) begin
                    next_state = GAME_RUNNING;
                end
            end
            GAME_RUNNING: begin
                if (running_done) begin
                    next_state = GAME_OVER;     // Out of time or goal reached
                end
            end
            GAME_OVER: begin
                if (click_valid) begin
                    next_state = START_SCREEN;  // Any click anywhere
                end
            end
            default: next_state = START_SCREEN;
        endcase
    end

    // Enables registered from next state to stay in step with state
    always_ff @(posedge clk) begin
        if (rst) begin
            state               <= START_SCREEN;
            start_screen_enable <= 1'b1;
            game_enable         <= 1'b0;
            game_end_enable     <= 1'b0;
            game_start          <= 1'b0;
            score_pulse         <= 1'b0;
        end else begin
            state               <= next_state;
            start_screen_enable <= (next_state == START_SCREEN);
            game_enable         <= (next_state == GAME_RUNNING);
            game_end_enable     <= (next_state == GAME_OVER);
            game_start          <= start_click;     // Single cycle
            score_pulse         <= score_click;     // Single cycle
        end
    end

    // Exactly one screen active
    enables_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot({start_screen_enable, game_enable, game_end_enable})
    );

endmodule

`default_nettype wire

// File: verilog/game_top.sv
// Game control top, joins click capture, hit detect, target placer, score timer and FSM
`timescale 1ns/1ns
`default_nettype none

module game_top import game_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               mouse_req,
    input  logic [COORD_W-1:0] click_x,
    input  logic [COORD_W-1:0] click_y,
    input  logic               frame_tick,
    output logic               mouse_ack,
    output logic               start_screen_enable,
    output logic               game_enable,
    output logic               game_end_enable,
    output logic [SCORE_W-1:0] score,
    output logic [TIME_W-1:0]  time_left,
    output logic [COORD_W-1:0] target_x,
    output logic [COORD_W-1:0] target_y
);

    logic               click_valid;
    logic [COORD_W-1:0] pos_x;      // Latched click position
    logic [COORD_W-1:0] pos_y;
    logic               start_hit;
    logic               target_hit;
    logic               game_finished;
    logic               game_start;
    logic               score_pulse;

    mouse_click_capture u_capture (
        .clk         (clk),
        .rst         (rst),
        .mouse_req   (mouse_req),
        .click_x     (click_x),
        .click_y     (click_y),
        .mouse_ack   (mouse_ack),
        .click_valid (click_valid),
        .pos_x       (pos_x),
        .pos_y       (pos_y)
    );

    area_hit_detect u_hit (
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .target_x   (target_x),
        .target_y   (target_y),
        .start_hit  (start_hit),
        .target_hit (target_hit)
    );

    target_placer u_placer (
        .clk         (clk),
        .rst         (rst),
        .game_start  (game_start),
        .score_pulse (score_pulse),
        .target_x    (target_x),
        .target_y    (target_y)
    );

    score_timer u_score (
        .clk           (clk),
        .rst           (rst),
        .game_start    (game_start),
        .score_pulse   (score_pulse),
        .game_enable   (game_enable),
        .frame_tick    (frame_tick),
        .score         (score),
        .time_left     (time_left),
        .game_finished (game_finished)
    );

    game_control_fsm u_fsm (
        .clk                 (clk),
        .rst                 (rst),
        .click_valid         (click_valid),
        .start_hit           (start_hit),
        .target_hit          (target_hit),
        .game_finished       (game_finished),
        .start_screen_enable (start_screen_enable),
        .game_enable         (game_enable),
        .game_end_enable     (game_end_enable),
        .game_start          (game_start),
        .score_pulse         (score_pulse)
    );

endmodule

`default_nettype wire

// File: testbench/tb_game_top.sv
// Testbench for the game control top that drives mouse clicks and frame ticks and checks the game flow
`timescale 1ns/1ns
`default_nettype none

module tb_game_top import game_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 50;                 // Per handshake phase
    localparam int HALF_TARGET    = TARGET_SIZE / 2;

    logic               clk;
    logic               rst;
    logic               mouse_req;
    logic [COORD_W-1:0] click_x;
    logic [COORD_W-1:0] click_y;
    logic               frame_tick;
    logic               mouse_ack;
    logic               start_screen_enable;
    logic               game_enable;
    logic               game_end_enable;
    logic [SCORE_W-1:0] score;
    logic [TIME_W-1:0]  time_left;
    logic [COORD_W-1:0] target_x;
    logic [COORD_W-1:0] target_y;

    int          errors;
    int          checks;
    int          tests;
    int          test_start_errors;   // Error count when the current test began
    int          exp_score;           // Score predicted from the game rules
    logic [31:0] lcg_state;

    game_top dut (
        .clk                 (clk),
        .rst                 (rst),
        .mouse_req           (mouse_req),
        .click_x             (click_x),
        .click_y             (click_y),
        .frame_tick          (frame_tick),
        .mouse_ack           (mouse_ack),
        .start_screen_enable (start_screen_enable),
        .game_enable         (game_enable),
        .game_end_enable     (game_end_enable),
        .score               (score),
        .time_left           (time_left),
        .target_x            (target_x),
        .target_y            (target_y)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Advance n edges and land 1 ns after the last one
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Lower edge inclusive, upper edge exclusive
    function automatic logic in_box(input int px, input int py, input int bx, input int by,
                                    input int bw, input int bh);
        return (px >= bx) && (px < bx + bw) && (py >= by) && (py < by + bh);
    endfunction

    // Random spot away from both the start button and the target
    task automatic pick_miss(output logic [COORD_W-1:0] x, output logic [COORD_W-1:0] y);
        int px;
        int py;
        do begin
            px = (lcg_next() >> 8) % SCREEN_W;
            py = (lcg_next() >> 8) % SCREEN_H;
        end while (in_box(px, py, START_BTN_X, START_BTN_Y, START_BTN_W, START_BTN_H)
                   || in_box(px, py, target_x, target_y, TARGET_SIZE, TARGET_SIZE));
        x = px[COORD_W-1:0];
        y = py[COORD_W-1:0];
    endtask

    // Full four-phase handshake plus one cycle for score, timer and target to follow
    task automatic click(input logic [COORD_W-1:0] x, input logic [COORD_W-1:0] y);
        int n;
        check_cond(!mouse_ack, "mouse_ack was still high before a new request");
        click_x   = x;
        click_y   = y;
        mouse_req = 1'b1;
        n = 0;
        while (!mouse_ack && n < TIMEOUT_CYCLES) begin
            step(1);
            n++;
        end
        check_cond(mouse_ack, "Timeout: mouse_ack did not rise after mouse_req");
        mouse_req = 1'b0;   // Coordinates no longer needed once acked
        n = 0;
        while (mouse_ack && n < TIMEOUT_CYCLES) begin
            step(1);
            n++;
        end
        check_cond(!mouse_ack, "Timeout: mouse_ack did not fall after mouse_req fell");
        step(1);
    endtask

    task automatic tick();
        frame_tick = 1'b1;
        step(1);
        frame_tick = 1'b0;
        step(1);
    endtask

    task automatic wait_game_over();
        int n;
        n = 0;
        while (!game_end_enable && n < TIMEOUT_CYCLES) begin
            step(1);
            n++;
        end
        check_cond(game_end_enable, "Timeout: game did not reach the game over screen");
    endtask

    // Far edges in full int width so a large position cannot wrap
    task automatic check_target_on_screen();
        int x_end;
        int y_end;
        x_end = target_x + TARGET_SIZE;
        y_end = target_y + TARGET_SIZE;
        check_cond(x_end <= SCREEN_W, "Target square leaves the screen in x");
        check_cond(y_end <= SCREEN_H, "Target square leaves the screen in y");
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            $display("Test %0d %s: ok", tests, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests, name, errors - test_start_errors);
        end
    endtask

    task automatic test_reset();
        begin_test();
        check("start_screen_enable", start_screen_enable, 1);
        check("game_enable", game_enable, 0);
        check("game_end_enable", game_end_enable, 0);
        check("score", score, 0);
        check("time_left", time_left, 0);
        check("target_x", target_x, TARGET_RESET_X);
        check("target_y", target_y, TARGET_RESET_Y);
        check("mouse_ack", mouse_ack, 0);
        end_test("reset state");
    endtask

    task automatic test_start_misses();
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        begin_test();
        repeat (8) begin
            pick_miss(x, y);
            click(x, y);
            check("start_screen_enable", start_screen_enable, 1);
            check("game_enable", game_enable, 0);
        end
        end_test("clicks beside start button");
    endtask

    task automatic test_game_start();
        begin_test();
        click(START_BTN_X, START_BTN_Y);    // Inclusive corner of the button
        exp_score = 0;                      // Cleared by game start
        check("game_enable", game_enable, 1);
        check("start_screen_enable", start_screen_enable, 0);
        check("time_left", time_left, GAME_TIME_TICKS);
        check("score", score, exp_score);
        check_target_on_screen();
        end_test("start button click");
    endtask

    task automatic test_hit_and_miss();
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        begin_test();
        click(target_x + HALF_TARGET, target_y + HALF_TARGET);
        exp_score++;
        check("score", score, exp_score);
        check_target_on_screen();
        pick_miss(x, y);
        click(x, y);
        check("score", score, exp_score);   // Miss keeps the score
        check("game_enable", game_enable, 1);
        end_test("target hit and miss");
    endtask

    task automatic test_time_out();
        logic [COORD_W-1:0] x;
        logic [COORD_W-1:0] y;
        begin_test();
        repeat (GAME_TIME_TICKS) tick();
        check("time_left", time_left, 0);
        wait_game_over();
        check("game_enable", game_enable, 0);
        repeat (3) tick();                  // Spent timer ignores ticks
        check("time_left", time_left, 0);
        check("game_end_enable", game_end_enable, 1);
        pick_miss(x, y);
        click(x, y);
        check("start_screen_enable", start_screen_enable, 1);
        check("game_end_enable", game_end_enable, 0);
        check("score", score, exp_score);
        end_test("timer runs out");
    endtask

    task automatic test_win();
        begin_test();
        click(START_BTN_X + START_BTN_W / 2, START_BTN_Y + START_BTN_H / 2);
        exp_score = 0;
        check("game_enable", game_enable, 1);
        check("score", score, exp_score);
        for (int i = 0; i < WIN_SCORE; i++) begin
            click(target_x + HALF_TARGET, target_y + HALF_TARGET);
            exp_score++;
            check("score", score, exp_score);
            check_target_on_screen();
        end
        wait_game_over();
        check("score", score, WIN_SCORE);
        check("game_enable", game_enable, 0);
        check_cond(time_left != 0, "Game ended on time rather than on the winning score");
        end_test("winning score");
    endtask

    initial begin
        rst        = 1'b1;
        mouse_req  = 1'b0;
        click_x    = '0;
        click_y    = '0;
        frame_tick = 1'b0;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        exp_score  = 0;
        lcg_state  = 32'h1fd3;
        step(2);                            // Two cycles in reset
        rst = 1'b0;
        step(1);

        test_reset();
        test_start_misses();
        test_game_start();
        test_hit_and_miss();
        test_time_out();
        test_win();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mouse_game.f
verilog/game_pkg.sv
verilog/mouse_click_capture.sv
verilog/area_hit_detect.sv
verilog/target_placer.sv
verilog/score_timer.sv
verilog/game_control_fsm.sv
verilog/game_top.sv
testbench/tb_game_top.sv
